//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP = tb_cmd_axi_bridge
FILELIST = tb.f
LOG = sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/cmd_arbiter.sv
`timescale 1ns/10ps

module cmd_arbiter #(
	parameter int addr_w = 32,
	parameter int data_w = 32,
	parameter int id_w = 4
) (
	input  logic rvx_port_31,
	input  logic rvx_port_13,

	input  logic src0_req,
	input  cmd_axi_pkg::cmd_class_t src0_class,
	input  logic [cmd_axi_pkg::code_w-1:0] src0_code,
	input  cmd_axi_pkg::size_code_t src0_size,
	input  logic [addr_w-1:0] src0_addr,
	input  logic [id_w-1:0] src0_id,
	input  logic [data_w/8-1:0] src0_strb,
	input  logic [data_w-1:0] src0_wdata,
	output logic src0_ready,

	input  logic src1_req,
	input  cmd_axi_pkg::cmd_class_t src1_class,
	input  logic [cmd_axi_pkg::code_w-1:0] src1_code,
	input  cmd_axi_pkg::size_code_t src1_size,
	input  logic [addr_w-1:0] src1_addr,
	input  logic [id_w-1:0] src1_id,
	input  logic [data_w/8-1:0] src1_strb,
	input  logic [data_w-1:0] src1_wdata,
	output logic src1_ready,

	output logic hold_valid,
	output cmd_axi_pkg::cmd_class_t hold_class,
	output logic [cmd_axi_pkg::code_w-1:0] hold_code,
	output cmd_axi_pkg::size_code_t hold_size,
	output logic [addr_w-1:0] hold_addr,
	output logic [id_w-1:0] hold_id,
	output logic [data_w/8-1:0] hold_strb,
	output logic [data_w-1:0] hold_wdata,
	input  logic hold_release
);

	// High when source 1 took the last grant
	logic last_winner;
	logic take0;
	logic take1;

	// Both sources see the same ready, the holding register has one slot
	assign src0_ready = ~hold_valid;
	assign src1_ready = ~hold_valid;

	// On a collision the source that lost last time wins
	assign take0 = src0_req & src0_ready & (~src1_req | last_winner);
	assign take1 = src1_req & src1_ready & ~take0;

	always_ff @(posedge rvx_port_31 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
		begin
			hold_valid <= 1'b0;
			last_winner <= 1'b0;
		end
		else if (hold_release)
			hold_valid <= 1'b0;
		else if (take0 | take1)
		begin
			hold_valid <= 1'b1;
			last_winner <= take1;
		end
	end

	// Held request fields
	always_ff @(posedge rvx_port_31)
	begin
		if (take0)
		begin
			hold_class <= src0_class;
			hold_code <= src0_code;
			hold_size <= src0_size;
			hold_addr <= src0_addr;
			hold_id <= src0_id;
			hold_strb <= src0_strb;
			hold_wdata <= src0_wdata;
		end
		else if (take1)
		begin
			hold_class <= src1_class;
			hold_code <= src1_code;
			hold_size <= src1_size;
			hold_addr <= src1_addr;
			hold_id <= src1_id;
			hold_strb <= src1_strb;
			hold_wdata <= src1_wdata;
		end
	end

	// The master may only release a request that is actually held
	a_release_held: assert property (@(posedge rvx_port_31) disable iff (!rvx_port_13)
		hold_release |-> hold_valid);

endmodule

//--- hdl/cmd_axi_bridge.sv
`timescale 1ns/10ps

module cmd_axi_bridge #(
	parameter int addr_w = 32,
	parameter int data_w = 32,
	parameter int id_w = 4
) (
	input  logic rvx_port_31,
	input  logic rvx_port_13,

	input  logic src0_req,
	input  cmd_axi_pkg::cmd_class_t src0_class,
	input  logic [cmd_axi_pkg::code_w-1:0] src0_code,
	input  cmd_axi_pkg::size_code_t src0_size,
	input  logic [addr_w-1:0] src0_addr,
	input  logic [id_w-1:0] src0_id,
	input  logic [data_w/8-1:0] src0_strb,
	input  logic [data_w-1:0] src0_wdata,
	output logic src0_ready,

	input  logic src1_req,
	input  cmd_axi_pkg::cmd_class_t src1_class,
	input  logic [cmd_axi_pkg::code_w-1:0] src1_code,
	input  cmd_axi_pkg::size_code_t src1_size,
	input  logic [addr_w-1:0] src1_addr,
	input  logic [id_w-1:0] src1_id,
	input  logic [data_w/8-1:0] src1_strb,
	input  logic [data_w-1:0] src1_wdata,
	output logic src1_ready,

	output logic [addr_w-1:0] ar_addr,
	output logic [cmd_axi_pkg::axi_len_w-1:0] ar_len,
	output logic [cmd_axi_pkg::axi_size_w-1:0] ar_size,
	output logic [cmd_axi_pkg::axi_burst_w-1:0] ar_burst,
	output logic ar_valid,
	input  logic ar_ready,

	output logic [addr_w-1:0] aw_addr,
	output logic [cmd_axi_pkg::axi_len_w-1:0] aw_len,
	output logic [cmd_axi_pkg::axi_size_w-1:0] aw_size,
	output logic [cmd_axi_pkg::axi_burst_w-1:0] aw_burst,
	output logic aw_valid,
	input  logic aw_ready,

	output logic [data_w-1:0] w_data,
	output logic [data_w/8-1:0] w_strb,
	output logic w_last,
	output logic w_valid,
	input  logic w_ready,

	output logic rd_issued,
	output logic [cmd_axi_pkg::tag_fixed_w+id_w-1:0] rd_tag,
	output logic wr_done,
	output logic [cmd_axi_pkg::tag_fixed_w+id_w-1:0] wr_tag,
	output logic fault
);

	import cmd_axi_pkg::*;

	// Held request between arbiter and master
	logic hold_valid;
	cmd_class_t hold_class;
	logic [code_w-1:0] hold_code;
	size_code_t hold_size;
	logic [addr_w-1:0] hold_addr;
	logic [id_w-1:0] hold_id;
	logic [data_w/8-1:0] hold_strb;
	logic [data_w-1:0] hold_wdata;
	logic hold_release;

	cmd_arbiter #(
		.addr_w(addr_w),
		.data_w(data_w),
		.id_w(id_w)
	) cmd_arbiter_inst (.*);

	cmd_axi_master #(
		.addr_w(addr_w),
		.data_w(data_w),
		.id_w(id_w)
	) cmd_axi_master_inst (.*);

endmodule

//--- hdl/cmd_axi_master.sv
`timescale 1ns/10ps

module cmd_axi_master #(
	parameter int addr_w = 32,
	parameter int data_w = 32,
	parameter int id_w = 4
) (
	input  logic rvx_port_31,
	input  logic rvx_port_13,

	input  logic hold_valid,
	input  cmd_axi_pkg::cmd_class_t hold_class,
	input  logic [cmd_axi_pkg::code_w-1:0] hold_code,
	input  cmd_axi_pkg::size_code_t hold_size,
	input  logic [addr_w-1:0] hold_addr,
	input  logic [id_w-1:0] hold_id,
	input  logic [data_w/8-1:0] hold_strb,
	input  logic [data_w-1:0] hold_wdata,
	output logic hold_release,

	output logic [addr_w-1:0] ar_addr,
	output logic [cmd_axi_pkg::axi_len_w-1:0] ar_len,
	output logic [cmd_axi_pkg::axi_size_w-1:0] ar_size,
	output logic [cmd_axi_pkg::axi_burst_w-1:0] ar_burst,
	output logic ar_valid,
	input  logic ar_ready,

	output logic [addr_w-1:0] aw_addr,
	output logic [cmd_axi_pkg::axi_len_w-1:0] aw_len,
	output logic [cmd_axi_pkg::axi_size_w-1:0] aw_size,
	output logic [cmd_axi_pkg::axi_burst_w-1:0] aw_burst,
	output logic aw_valid,
	input  logic aw_ready,

	output logic [data_w-1:0] w_data,
	output logic [data_w/8-1:0] w_strb,
	output logic w_last,
	output logic w_valid,
	input  logic w_ready,

	output logic rd_issued,
	output logic [cmd_axi_pkg::tag_fixed_w+id_w-1:0] rd_tag,
	output logic wr_done,
	output logic [cmd_axi_pkg::tag_fixed_w+id_w-1:0] wr_tag,
	output logic fault
);

	import cmd_axi_pkg::*;

	bridge_state_t state;
	cmd_op_t op;
	logic bad_size;
	logic bad_cmd;
	logic [axi_len_w-1:0] dec_len;
	logic [axi_size_w-1:0] dec_size;
	logic [axi_burst_w-1:0] dec_burst;
	logic [axi_len_w-1:0] len_q;
	logic [axi_size_w-1:0] size_q;
	logic [axi_burst_w-1:0] burst_q;
	logic [axi_len_w-1:0] beat_cnt;
	logic [tag_fixed_w+id_w-1:0] tag;

	// ****************************************
	// Request decode
	// ****************************************
	assign op = decode_op(hold_class, hold_code);

	always_comb
	begin
		dec_len = len_1;
		dec_size = axi_size_4b;
		dec_burst = burst_incr;
		bad_size = 1'b0;
		case (hold_size)
			sz_byte, sz_half, sz_word:
			begin
				// Single beat, size follows the code directly
				dec_burst = burst_fixed;
				dec_size = hold_size;
			end
			sz_incr2: dec_len = len_2;
			sz_incr4: dec_len = len_4;
			sz_incr8: dec_len = len_8;
			sz_incr16: dec_len = len_16;
			default: bad_size = 1'b1;
		endcase
	end

	assign bad_cmd = (op == op_illegal) | bad_size;

	// ****************************************
	// Control FSM
	// ****************************************
	always_ff @(posedge rvx_port_31 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
			state <= st_idle;
		else
			case (state)
				st_idle:
					if (hold_valid)
					begin
						if (bad_cmd)
							state <= st_fault;
						else if (op == op_read)
							state <= st_rd_addr;
						else
							state <= st_wr_addr;
					end
				st_rd_addr:
					if (ar_ready)
						state <= st_idle;
				st_wr_addr:
					if (aw_ready)
						state <= st_wr_data;
				st_wr_data:
					if (w_ready && w_last)
						state <= st_idle;
				// Fault is sticky until reset
				default: state <= st_fault;
			endcase
	end

	// Burst fields captured when a request leaves idle
	always_ff @(posedge rvx_port_31)
	begin
		if (state == st_idle && hold_valid)
		begin
			len_q <= dec_len;
			size_q <= dec_size;
			burst_q <= dec_burst;
		end
	end

	// Remaining W beats, zero on the last one
	always_ff @(posedge rvx_port_31 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
			beat_cnt <= '0;
		else if (state == st_idle && hold_valid && op == op_write)
			beat_cnt <= dec_len;
		else if (w_valid && w_ready)
			beat_cnt <= beat_cnt - 1'b1;
	end

	// ****************************************
	// AXI outputs and events
	// ****************************************
	assign ar_addr = hold_addr;
	assign ar_len = len_q;
	assign ar_size = size_q;
	assign ar_burst = burst_q;
	assign ar_valid = (state == st_rd_addr);

	assign aw_addr = hold_addr;
	assign aw_len = len_q;
	assign aw_size = size_q;
	assign aw_burst = burst_q;
	assign aw_valid = (state == st_wr_addr);

	// Every beat repeats the held word and strobes
	assign w_data = hold_wdata;
	assign w_strb = hold_strb;
	assign w_last = (beat_cnt == '0);
	assign w_valid = (state == st_wr_data);

	assign tag = {hold_class, hold_code, hold_id, hold_size};
	assign rd_issued = ar_valid & ar_ready;
	assign rd_tag = tag;
	assign wr_done = w_valid & w_ready & w_last;
	assign wr_tag = tag;
	assign hold_release = rd_issued | wr_done;
	assign fault = (state == st_fault);

	a_one_addr_valid: assert property (@(posedge rvx_port_31) disable iff (!rvx_port_13)
		!(ar_valid && aw_valid));

	// Address must not move while the slave stalls AR
	a_ar_addr_stable: assert property (@(posedge rvx_port_31) disable iff (!rvx_port_13)
		(ar_valid && !ar_ready) |=> $stable(ar_addr));

endmodule

//--- hdl/cmd_axi_pkg.sv
package cmd_axi_pkg;

	// Command class, only two values are legal
	typedef logic [2:0] cmd_class_t;
	localparam cmd_class_t cls_std = 3'd1;
	localparam cmd_class_t cls_ext = 3'd2;

	localparam int code_w = 3;

	// Result of the class and sub-code decode
	typedef enum logic [1:0] {op_illegal, op_read, op_write} cmd_op_t;

	function automatic cmd_op_t decode_op(input cmd_class_t cls, input logic [code_w-1:0] code);
		cmd_op_t op;
		op = op_illegal;
		case (cls)
			cls_std:
				case (code)
					3'd4, 3'd6: op = op_read;
					3'd0, 3'd1: op = op_write;
					default: op = op_illegal;
				endcase
			cls_ext:
				case (code)
					3'd1: op = op_read;
					3'd0, 3'd7: op = op_write;
					default: op = op_illegal;
				endcase
			default: op = op_illegal;
		endcase
		return op;
	endfunction

	// Size codes, 0 to 2 are single fixed beats, 3 to 6 are word bursts
	typedef logic [2:0] size_code_t;
	localparam size_code_t sz_byte = 3'd0;
	localparam size_code_t sz_half = 3'd1;
	localparam size_code_t sz_word = 3'd2;
	localparam size_code_t sz_incr2 = 3'd3;
	localparam size_code_t sz_incr4 = 3'd4;
	localparam size_code_t sz_incr8 = 3'd5;
	localparam size_code_t sz_incr16 = 3'd6;

	// ****************************************
	// AXI field widths and constants
	// ****************************************
	localparam int axi_len_w = 8;
	localparam int axi_size_w = 3;
	localparam int axi_burst_w = 2;

	localparam logic [axi_burst_w-1:0] burst_fixed = 2'b00;
	localparam logic [axi_burst_w-1:0] burst_incr = 2'b01;
	localparam logic [axi_size_w-1:0] axi_size_4b = 3'd2;

	// AXI length is beats minus one
	localparam logic [axi_len_w-1:0] len_1 = 8'd0;
	localparam logic [axi_len_w-1:0] len_2 = 8'd1;
	localparam logic [axi_len_w-1:0] len_4 = 8'd3;
	localparam logic [axi_len_w-1:0] len_8 = 8'd7;
	localparam logic [axi_len_w-1:0] len_16 = 8'd15;

	// Class, sub-code and size code bits of a tag, the ID comes on top
	localparam int tag_fixed_w = 9;

	typedef enum logic [2:0] {
		st_idle,
		st_rd_addr,
		st_wr_addr,
		st_wr_data,
		st_fault
	} bridge_state_t;

endpackage

//--- tb.f
hdl/cmd_axi_pkg.sv
hdl/cmd_arbiter.sv
hdl/cmd_axi_master.sv
hdl/cmd_axi_bridge.sv
tb/bridge_checker.sv
tb/tb_cmd_axi_bridge.sv

//--- tb/bridge_checker.sv
`timescale 1ns/10ps

module bridge_checker #(
	parameter int addr_w = 32,
	parameter int data_w = 32,
	parameter int id_w = 4
) (
	input  logic rvx_port_31,
	input  logic rvx_port_13,

	input  logic src0_req,
	input  cmd_axi_pkg::cmd_class_t src0_class,
	input  logic [cmd_axi_pkg::code_w-1:0] src0_code,
	input  cmd_axi_pkg::size_code_t src0_size,
	input  logic [addr_w-1:0] src0_addr,
	input  logic [id_w-1:0] src0_id,
	input  logic [data_w/8-1:0] src0_strb,
	input  logic [data_w-1:0] src0_wdata,
	input  logic src0_ready,

	input  logic src1_req,
	input  cmd_axi_pkg::cmd_class_t src1_class,
	input  logic [cmd_axi_pkg::code_w-1:0] src1_code,
	input  cmd_axi_pkg::size_code_t src1_size,
	input  logic [addr_w-1:0] src1_addr,
	input  logic [id_w-1:0] src1_id,
	input  logic [data_w/8-1:0] src1_strb,
	input  logic [data_w-1:0] src1_wdata,
	input  logic src1_ready,

	input  logic [addr_w-1:0] ar_addr,
	input  logic [cmd_axi_pkg::axi_len_w-1:0] ar_len,
	input  logic [cmd_axi_pkg::axi_size_w-1:0] ar_size,
	input  logic [cmd_axi_pkg::axi_burst_w-1:0] ar_burst,
	input  logic ar_valid,
	input  logic ar_ready,

	input  logic [addr_w-1:0] aw_addr,
	input  logic [cmd_axi_pkg::axi_len_w-1:0] aw_len,
	input  logic [cmd_axi_pkg::axi_size_w-1:0] aw_size,
	input  logic [cmd_axi_pkg::axi_burst_w-1:0] aw_burst,
	input  logic aw_valid,
	input  logic aw_ready,

	input  logic [data_w-1:0] w_data,
	input  logic [data_w/8-1:0] w_strb,
	input  logic w_last,
	input  logic w_valid,
	input  logic w_ready,

	input  logic rd_issued,
	input  logic [cmd_axi_pkg::tag_fixed_w+id_w-1:0] rd_tag,
	input  logic wr_done,
	input  logic [cmd_axi_pkg::tag_fixed_w+id_w-1:0] wr_tag,
	input  logic fault,

	output int error_count,
	output int check_count
);

	import cmd_axi_pkg::*;

	localparam int tag_w = tag_fixed_w + id_w;

	int errors = 0;
	int checks = 0;
	int exp_op;
	int beats_left;
	logic holding;
	logic free;
	logic win1;
	logic last1;
	logic aw_seen;
	logic faulted;
	logic exp_bad;
	logic ar_wait;
	logic aw_wait;
	logic w_wait;
	logic [addr_w-1:0] exp_addr;
	logic [axi_len_w-1:0] exp_len;
	logic [axi_size_w-1:0] exp_size;
	logic [axi_burst_w-1:0] exp_burst;
	logic [data_w/8-1:0] exp_strb;
	logic [data_w-1:0] exp_wdata;
	logic [tag_w-1:0] exp_tag;

	assign error_count = errors;
	assign check_count = checks;

	task automatic expect_true(input logic ok, input string msg);
		checks++;
		if (!ok)
		begin
			errors++;
			$display("ERROR %0t: %s", $time, msg);
		end
	endtask

	// 0 illegal, 1 read, 2 write
	function automatic int predict_op(input logic [2:0] cls, input logic [2:0] code);
		if (cls == cls_std && (code == 3'd4 || code == 3'd6))
			return 1;
		if (cls == cls_std && code <= 3'd1)
			return 2;
		if (cls == cls_ext && code == 3'd1)
			return 1;
		if (cls == cls_ext && (code == 3'd0 || code == 3'd7))
			return 2;
		return 0;
	endfunction

	// Codes below 3 are one fixed beat, above that bursts of 2 to 16 words
	task automatic capture(input logic [2:0] cls, input logic [2:0] code,
		input logic [2:0] size, input logic [addr_w-1:0] addr, input logic [id_w-1:0] id,
		input logic [data_w/8-1:0] strb, input logic [data_w-1:0] wdata);
		int beats;
		beats = (size < 3'd3) ? 1 : (1 << (size - 3'd2));
		exp_op = predict_op(cls, code);
		exp_bad = (exp_op == 0) || (size == 3'd7);
		exp_len = axi_len_w'(beats - 1);
		exp_size = (size < 3'd3) ? size : 3'd2;
		exp_burst = (size < 3'd3) ? burst_fixed : burst_incr;
		exp_addr = addr;
		exp_strb = strb;
		exp_wdata = wdata;
		exp_tag = {cls, code, id, size};
		holding = 1'b1;
	endtask

	always @(posedge rvx_port_31 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
		begin
			holding = 1'b0;
			last1 = 1'b0;
			aw_seen = 1'b0;
			faulted = 1'b0;
			exp_op = 0;
			exp_bad = 1'b0;
			beats_left = 0;
			ar_wait = 1'b0;
			aw_wait = 1'b0;
			w_wait = 1'b0;
		end
		else
		begin
			free = !holding;
			expect_true(src0_ready == free && src1_ready == free,
				"source ready does not follow the holding slot");

			// ****************************************
			// Fault
			// ****************************************
			if (faulted)
				expect_true(fault, "fault dropped before reset");
			if (fault && !faulted)
			begin
				expect_true(holding && exp_bad, "fault raised for a legal request");
				faulted = 1'b1;
			end
			if (fault)
				expect_true(!ar_valid && !aw_valid && !w_valid && !rd_issued && !wr_done,
					"AXI activity while the fault is set");

			// A valid may not drop before its ready
			if (ar_wait)
				expect_true(ar_valid, "ar_valid dropped before ar_ready");
			if (aw_wait)
				expect_true(aw_valid, "aw_valid dropped before aw_ready");
			if (w_wait)
				expect_true(w_valid, "w_valid dropped before w_ready");

			// ****************************************
			// Address channels
			// ****************************************
			expect_true(rd_issued == (ar_valid && ar_ready),
				"rd_issued is not the AR handshake");
			if (ar_valid)
			begin
				expect_true(holding && exp_op == 1 && !exp_bad, "AR valid without a held read");
				expect_true(ar_addr == exp_addr && ar_len == exp_len && ar_size == exp_size &&
					ar_burst == exp_burst,
					$sformatf("AR %h len %0d size %0d burst %0d, expected %h %0d %0d %0d",
					ar_addr, ar_len, ar_size, ar_burst, exp_addr, exp_len, exp_size, exp_burst));
				if (ar_ready)
				begin
					expect_true(rd_tag == exp_tag,
						$sformatf("rd_tag %h, expected %h", rd_tag, exp_tag));
					holding = 1'b0;
				end
			end

			if (aw_valid)
			begin
				expect_true(holding && exp_op == 2 && !exp_bad && !aw_seen,
					"AW valid without a held write");
				expect_true(aw_addr == exp_addr && aw_len == exp_len && aw_size == exp_size &&
					aw_burst == exp_burst,
					$sformatf("AW %h len %0d size %0d burst %0d, expected %h %0d %0d %0d",
					aw_addr, aw_len, aw_size, aw_burst, exp_addr, exp_len, exp_size, exp_burst));
				if (aw_ready)
				begin
					aw_seen = 1'b1;
					beats_left = int'(exp_len) + 1;
				end
			end

			// ****************************************
			// Write data
			// ****************************************
			expect_true(wr_done == (w_valid && w_ready && beats_left == 1),
				"wr_done is not the last W handshake");
			if (w_valid)
			begin
				expect_true(aw_seen, "W beat before the AW handshake");
				expect_true(w_data == exp_wdata && w_strb == exp_strb,
					$sformatf("W beat %h/%h, expected %h/%h",
					w_data, w_strb, exp_wdata, exp_strb));
				expect_true(w_last == (beats_left == 1),
					$sformatf("w_last %b with %0d beats left", w_last, beats_left));
				if (w_ready)
				begin
					beats_left--;
					if (beats_left == 0)
					begin
						expect_true(wr_tag == exp_tag,
							$sformatf("wr_tag %h, expected %h", wr_tag, exp_tag));
						holding = 1'b0;
						aw_seen = 1'b0;
					end
				end
			end

			ar_wait = ar_valid && !ar_ready;
			aw_wait = aw_valid && !aw_ready;
			w_wait = w_valid && !w_ready;

			// On a collision the source that lost last time wins
			if (free && (src0_req || src1_req))
			begin
				win1 = src1_req && (!src0_req || !last1);
				last1 = win1;
				if (win1)
					capture(src1_class, src1_code, src1_size, src1_addr, src1_id,
						src1_strb, src1_wdata);
				else
					capture(src0_class, src0_code, src0_size, src0_addr, src0_id,
						src0_strb, src0_wdata);
			end
		end
	end

endmodule

//--- tb/tb_cmd_axi_bridge.sv
`timescale 1ns/10ps

module tb_cmd_axi_bridge;

	import cmd_axi_pkg::*;

	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int id_w = 4;
	localparam int tag_w = tag_fixed_w + id_w;
	localparam int n_rows = 14;
	// Longest burst plus slack per row, with room for random back-pressure
	localparam int cycle_limit = n_rows * (16 + 20) * 4;

	localparam int k_read = 0;
	localparam int k_write = 1;
	localparam int k_fault = 2;
	localparam int src_both = 2;

	logic rvx_port_31;
	logic rvx_port_13;

	logic src0_req;
	cmd_class_t src0_class;
	logic [code_w-1:0] src0_code;
	size_code_t src0_size;
	logic [addr_w-1:0] src0_addr;
	logic [id_w-1:0] src0_id;
	logic [data_w/8-1:0] src0_strb;
	logic [data_w-1:0] src0_wdata;
	logic src0_ready;

	logic src1_req;
	cmd_class_t src1_class;
	logic [code_w-1:0] src1_code;
	size_code_t src1_size;
	logic [addr_w-1:0] src1_addr;
	logic [id_w-1:0] src1_id;
	logic [data_w/8-1:0] src1_strb;
	logic [data_w-1:0] src1_wdata;
	logic src1_ready;

	logic [addr_w-1:0] ar_addr;
	logic [axi_len_w-1:0] ar_len;
	logic [axi_size_w-1:0] ar_size;
	logic [axi_burst_w-1:0] ar_burst;
	logic ar_valid;
	logic ar_ready;

	logic [addr_w-1:0] aw_addr;
	logic [axi_len_w-1:0] aw_len;
	logic [axi_size_w-1:0] aw_size;
	logic [axi_burst_w-1:0] aw_burst;
	logic aw_valid;
	logic aw_ready;

	logic [data_w-1:0] w_data;
	logic [data_w/8-1:0] w_strb;
	logic w_last;
	logic w_valid;
	logic w_ready;

	logic rd_issued;
	logic [tag_w-1:0] rd_tag;
	logic wr_done;
	logic [tag_w-1:0] wr_tag;
	logic fault;

	int error_count;
	int check_count;
	int cycle_count = 0;

	// Stimulus table, one request per row
	int row_src [n_rows];
	logic [2:0] row_class [n_rows];
	logic [2:0] row_code [n_rows];
	logic [2:0] row_size [n_rows];
	logic [addr_w-1:0] row_addr [n_rows];
	logic [id_w-1:0] row_id [n_rows];
	logic [data_w/8-1:0] row_strb [n_rows];
	logic [data_w-1:0] row_wdata [n_rows];
	int row_kind [n_rows];
	int row_winner [n_rows];

	cmd_axi_bridge #(
		.addr_w(addr_w),
		.data_w(data_w),
		.id_w(id_w)
	) cmd_axi_bridge_inst (.*);

	bridge_checker #(
		.addr_w(addr_w),
		.data_w(data_w),
		.id_w(id_w)
	) bridge_checker_inst (.*);

	initial
	begin
		rvx_port_31 = 1'b0;
		forever #50 rvx_port_31 = ~rvx_port_31;
	end

	// Slave side, random back-pressure on every channel
	initial
	begin
		void'($urandom(32'h3786c7e1));
		forever
		begin
			@(posedge rvx_port_31);
			ar_ready <= ($urandom % 3) != 0;
			aw_ready <= ($urandom % 3) != 0;
			w_ready <= ($urandom % 2) != 0;
		end
	end

	always @(posedge rvx_port_31)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ****************************************
	// Table and drive tasks
	// ****************************************
	task automatic set_row(input int idx, input int src, input logic [2:0] cls,
		input logic [2:0] code, input logic [2:0] size, input logic [addr_w-1:0] addr,
		input logic [id_w-1:0] id, input logic [data_w/8-1:0] strb,
		input logic [data_w-1:0] wdata, input int kind, input int winner);
		row_src[idx] = src;
		row_class[idx] = cls;
		row_code[idx] = code;
		row_size[idx] = size;
		row_addr[idx] = addr;
		row_id[idx] = id;
		row_strb[idx] = strb;
		row_wdata[idx] = wdata;
		row_kind[idx] = kind;
		row_winner[idx] = winner;
	endtask

	task automatic load_table();
		set_row(0, 0, cls_std, 3'd4, 3'd0, 32'h0000_1000, 4'h1, 4'b0001, 32'ha5a5_0001, k_read, 0);
		set_row(1, 1, cls_std, 3'd6, 3'd1, 32'h0000_1102, 4'h2, 4'b0011, 32'ha5a5_0002, k_read, 1);
		set_row(2, 0, cls_ext, 3'd1, 3'd6, 32'h0000_2000, 4'h3, 4'b1111, 32'ha5a5_0003, k_read, 0);
		set_row(3, 1, cls_std, 3'd0, 3'd2, 32'h0000_3000, 4'h4, 4'b1111, 32'hc0de_0004, k_write, 1);
		set_row(4, 0, cls_std, 3'd1, 3'd3, 32'h0000_3100, 4'h5, 4'b1111, 32'hc0de_0005, k_write, 0);
		set_row(5, 1, cls_ext, 3'd0, 3'd4, 32'h0000_3200, 4'h6, 4'b1100, 32'hc0de_0006, k_write, 1);
		set_row(6, 0, cls_ext, 3'd7, 3'd5, 32'h0000_3300, 4'h7, 4'b0110, 32'hc0de_0007, k_write, 0);
		set_row(7, 1, cls_std, 3'd1, 3'd6, 32'h0000_4000, 4'h8, 4'b1111, 32'hc0de_0008, k_write, 1);
		set_row(8, src_both, cls_std, 3'd4, 3'd4, 32'h0000_5000, 4'h9, 4'b1111, 32'h0, k_read, 0);
		set_row(9, 0, cls_std, 3'd6, 3'd2, 32'h0000_5100, 4'ha, 4'b1111, 32'h0, k_read, 0);
		set_row(10, src_both, cls_ext, 3'd0, 3'd3, 32'h0000_6000, 4'hb, 4'b1111,
			32'h1234_5678, k_write, 1);
		// Illegal sub-code, class and size code, each after a fresh reset
		set_row(11, 0, cls_std, 3'd2, 3'd2, 32'h0000_7000, 4'hc, 4'b1111, 32'h0, k_fault, 0);
		set_row(12, 1, 3'd5, 3'd0, 3'd2, 32'h0000_7100, 4'hd, 4'b1111, 32'h0, k_fault, 1);
		set_row(13, 0, cls_ext, 3'd1, 3'd7, 32'h0000_7200, 4'he, 4'b1111, 32'h0, k_fault, 0);
	endtask

	task automatic apply_reset();
		rvx_port_13 <= 1'b0;
		repeat (5) @(posedge rvx_port_31);
		rvx_port_13 <= 1'b1;
	endtask

	// Alternate fields keep the two sources apart in a collision row
	task automatic drive_source(input int src, input int idx, input bit alt);
		logic [addr_w-1:0] addr;
		logic [id_w-1:0] id;
		logic [data_w-1:0] wdata;
		addr = alt ? row_addr[idx] + 32'h40 : row_addr[idx];
		id = alt ? ~row_id[idx] : row_id[idx];
		wdata = alt ? ~row_wdata[idx] : row_wdata[idx];
		if (src == 0)
		begin
			src0_req <= 1'b1;
			src0_class <= row_class[idx];
			src0_code <= row_code[idx];
			src0_size <= row_size[idx];
			src0_addr <= addr;
			src0_id <= id;
			src0_strb <= row_strb[idx];
			src0_wdata <= wdata;
		end
		else
		begin
			src1_req <= 1'b1;
			src1_class <= row_class[idx];
			src1_code <= row_code[idx];
			src1_size <= row_size[idx];
			src1_addr <= addr;
			src1_id <= id;
			src1_strb <= row_strb[idx];
			src1_wdata <= wdata;
		end
	endtask

	task automatic send_until_taken(input int src, input int idx, input bit alt);
		logic taken;
		taken = 1'b0;
		drive_source(src, idx, alt);
		while (!taken)
		begin
			@(posedge rvx_port_31);
			taken = (src == 0) ? src0_ready : src1_ready;
		end
		src0_req <= 1'b0;
		src1_req <= 1'b0;
	endtask

	task automatic wait_done(input int kind);
		logic seen;
		seen = 1'b0;
		while (!seen)
		begin
			@(posedge rvx_port_31);
			if (kind == k_read)
				seen = rd_issued;
			else if (kind == k_write)
				seen = wr_done;
			else
				seen = fault;
		end
	endtask

	// Both strobe once, the loser retries after the winner is done
	task automatic run_collision(input int idx);
		int loser;
		loser = 1 - row_winner[idx];
		drive_source(0, idx, 1'b0);
		drive_source(1, idx, 1'b1);
		@(posedge rvx_port_31);
		src0_req <= 1'b0;
		src1_req <= 1'b0;
		wait_done(row_kind[idx]);
		send_until_taken(loser, idx, loser == 1);
		wait_done(row_kind[idx]);
	endtask

	// ****************************************
	// Main sequence
	// ****************************************
	initial
	begin
		rvx_port_13 = 1'b0;
		src0_req = 1'b0;
		src0_class = '0;
		src0_code = '0;
		src0_size = '0;
		src0_addr = '0;
		src0_id = '0;
		src0_strb = '0;
		src0_wdata = '0;
		src1_req = 1'b0;
		src1_class = '0;
		src1_code = '0;
		src1_size = '0;
		src1_addr = '0;
		src1_id = '0;
		src1_strb = '0;
		src1_wdata = '0;
		ar_ready = 1'b0;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		load_table();
		apply_reset();

		for (int i = 0; i < n_rows; i++)
		begin
			if (row_kind[i] == k_fault && i > 0 && row_kind[i-1] == k_fault)
				apply_reset();
			if (row_src[i] == src_both)
				run_collision(i);
			else
			begin
				send_until_taken(row_src[i], i, 1'b0);
				wait_done(row_kind[i]);
			end
		end

		// Strobes while the fault is set must all be ignored
		repeat (20)
		begin
			@(posedge rvx_port_31);
			src0_req <= ~src0_req;
			src1_req <= ~src1_req;
		end
		@(posedge rvx_port_31);
		src0_req <= 1'b0;
		src1_req <= 1'b0;
		repeat (4) @(posedge rvx_port_31);
		@(negedge rvx_port_31);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
